// File: rtl/avmm_pkg.sv
// ------------------------------
// Avalon memory subsystem package
// Bus widths, the request and response
// beat structs and the single-word memory
// command passed from decoder to RAM
// ------------------------------

package avmm_pkg;

    // Word address width, 1024 words of storage
    localparam int AVMM_ADDR_W = 10;

    // Data bus width in bits
    localparam int AVMM_DATA_W = 32;

    // One enable per data byte
    localparam int AVMM_BE_W = AVMM_DATA_W / 8;

    // Burst length field, bursts run from 1 to 8 beats
    localparam int AVMM_BURST_W = 4;

    // Number of words held by the RAM
    localparam int AVMM_DEPTH = 1 << AVMM_ADDR_W;

    // One Avalon request beat as driven by the host
    // Read and write are the request strobes and are never high together
    typedef struct packed {
        logic [AVMM_ADDR_W-1:0]  address;
        logic [AVMM_BURST_W-1:0] burstcount;
        logic [AVMM_DATA_W-1:0]  writedata;
        logic [AVMM_BE_W-1:0]    byteenable;
        logic                    read;
        logic                    write;
    } avmm_req_t;

    // One read response beat
    // The response channel has no back-pressure
    typedef struct packed {
        logic [AVMM_DATA_W-1:0] readdata;
        logic                   readdatavalid;
    } avmm_rsp_t;

    // Operation carried by a single-word memory command
    typedef enum logic [1:0] {
        MEM_IDLE  = 2'd0,
        MEM_READ  = 2'd1,
        MEM_WRITE = 2'd2
    } mem_op_e;

    // One word access after burst sequencing
    // The address already includes the beat offset within the burst
    typedef struct packed {
        mem_op_e                op;
        logic [AVMM_ADDR_W-1:0] addr;
        logic [AVMM_DATA_W-1:0] wdata;
        logic [AVMM_BE_W-1:0]   be;
    } mem_cmd_t;

endpackage

// File: rtl/avmm_ready_skid.sv
// ------------------------------
// Ready/enable skid buffer
// Two entries, an output register and a
// skid register, so that both the data and
// the ready seen by the source are registered
// ------------------------------

`timescale 1ns/1ps

module avmm_ready_skid #(
    parameter int N_DATA_BITS = 8
) (
    input  logic                   clk,
    input  logic                   rst,

    input  logic                   enable_from_src,
    input  logic [N_DATA_BITS-1:0] data_from_src,
    output logic                   ready_to_src,

    output logic                   enable_to_dst,
    output logic [N_DATA_BITS-1:0] data_to_dst,
    input  logic                   ready_from_dst
);

    logic                   out_valid;
    logic [N_DATA_BITS-1:0] out_data;
    logic                   skid_valid;
    logic                   skid_valid_nxt;
    logic [N_DATA_BITS-1:0] skid_data;
    logic                   ready_q;
    logic                   src_accept;
    logic                   out_load;

    // A beat moves in from the source only while the skid entry is free
    assign src_accept = enable_from_src && ready_q;

    // The output register may be refilled when it is empty or being consumed
    assign out_load = ready_from_dst || !out_valid;

    always_comb
    begin
        skid_valid_nxt = skid_valid;
        // Refilling the output always drains the skid entry first
        if (out_load)
            skid_valid_nxt = 1'b0;
        else if (src_accept)
            skid_valid_nxt = 1'b1;
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            out_valid  <= 1'b0;
            skid_valid <= 1'b0;
            ready_q    <= 1'b0;
        end
        else
        begin
            if (out_load)
                out_valid <= skid_valid || src_accept;
            skid_valid <= skid_valid_nxt;
            // Ready is a flop, low while reset is asserted
            ready_q    <= !skid_valid_nxt;
        end
    end

    // Older beat in the skid entry goes out before any new one
    always_ff @(posedge clk)
    begin
        if (out_load)
            out_data <= skid_valid ? skid_data : data_from_src;
        if (!out_load && src_accept)
            skid_data <= data_from_src;
    end

    assign ready_to_src  = ready_q;
    assign enable_to_dst = out_valid;
    assign data_to_dst   = out_data;

    // A stalled beat must not change until the destination takes it
    a_hold_on_stall: assert property (@(posedge clk) disable iff (rst)
        enable_to_dst && !ready_from_dst |=> enable_to_dst && $stable(data_to_dst));

endmodule

// File: rtl/avmm_if_skid.sv
// ------------------------------
// Avalon skid stage
// Optional registered request path with
// flow control and an optional register on
// the read response path
// ------------------------------

`timescale 1ns/1ps

module avmm_if_skid import avmm_pkg::*; #(
    parameter int SKID_REQ = 1,
    parameter int REG_RSP  = 1
) (
    input  logic      clk,
    input  logic      rst,

    input  avmm_req_t host_req,
    output logic      host_waitrequest,
    output avmm_rsp_t host_rsp,

    output avmm_req_t mem_req,
    input  logic      mem_waitrequest,
    input  avmm_rsp_t mem_rsp
);

    generate
        if (SKID_REQ != 0)
        begin : g_skid_req
            logic      req_ready;
            logic      req_valid;
            avmm_req_t skid_req;

            // The whole request beat travels as one packed vector
            avmm_ready_skid #(
                .N_DATA_BITS($bits(avmm_req_t))
            ) req_skid_i (
                .clk            (clk),
                .rst            (rst),
                .enable_from_src(host_req.read || host_req.write),
                .data_from_src  (host_req),
                .ready_to_src   (req_ready),
                .enable_to_dst  (req_valid),
                .data_to_dst    (skid_req),
                .ready_from_dst (!mem_waitrequest)
            );

            assign host_waitrequest = !req_ready;

            // Stale strobes in an empty skid slot must not reach the decoder
            always_comb
            begin
                mem_req       = skid_req;
                mem_req.read  = skid_req.read && req_valid;
                mem_req.write = skid_req.write && req_valid;
            end
        end
        else
        begin : g_wire_req
            assign host_waitrequest = mem_waitrequest;
            assign mem_req          = host_req;
        end

        if (REG_RSP != 0)
        begin : g_reg_rsp
            // No back-pressure on responses, so one register is enough
            always_ff @(posedge clk)
            begin
                if (rst)
                    host_rsp.readdatavalid <= 1'b0;
                else
                    host_rsp.readdatavalid <= mem_rsp.readdatavalid;
                host_rsp.readdata <= mem_rsp.readdata;
            end
        end
        else
        begin : g_wire_rsp
            assign host_rsp = mem_rsp;
        end
    endgenerate

endmodule

// File: rtl/avmm_burst_decode.sv
// ------------------------------
// Avalon burst decoder
// Splits single and burst requests into
// one memory command per word and stalls
// the host while a read burst is replayed
// ------------------------------

`timescale 1ns/1ps

module avmm_burst_decode import avmm_pkg::*; (
    input  logic      clk,
    input  logic      rst,

    input  avmm_req_t mem_req,
    output logic      mem_waitrequest,
    output mem_cmd_t  mem_cmd
);

    typedef enum logic [1:0] {
        DEC_IDLE     = 2'd0,
        DEC_WR_BURST = 2'd1,
        DEC_RD_BURST = 2'd2
    } dec_state_e;

    dec_state_e              state;
    dec_state_e              state_nxt;
    logic [AVMM_ADDR_W-1:0]  base_addr;
    logic [AVMM_BURST_W-1:0] beat_idx;
    logic [AVMM_BURST_W-1:0] beats_left;
    logic [AVMM_BURST_W-1:0] req_len;
    logic                    wait_q;
    logic                    beat_acc;

    assign mem_waitrequest = wait_q;
    assign beat_acc = (mem_req.read || mem_req.write) && !wait_q;

    // A burstcount of zero counts as a single beat
    assign req_len = (mem_req.burstcount == '0) ? AVMM_BURST_W'(1) : mem_req.burstcount;

    always_comb
    begin
        state_nxt     = state;
        mem_cmd.op    = MEM_IDLE;
        mem_cmd.addr  = base_addr + AVMM_ADDR_W'(beat_idx);
        mem_cmd.wdata = mem_req.writedata;
        mem_cmd.be    = mem_req.byteenable;
        case (state)
            DEC_IDLE:
            begin
                // First beat uses its own address, later beats the saved base
                mem_cmd.addr = mem_req.address;
                if (beat_acc && mem_req.write)
                begin
                    mem_cmd.op = MEM_WRITE;
                    if (req_len > AVMM_BURST_W'(1))
                        state_nxt = DEC_WR_BURST;
                end
                else if (beat_acc && mem_req.read)
                begin
                    mem_cmd.op = MEM_READ;
                    if (req_len > AVMM_BURST_W'(1))
                        state_nxt = DEC_RD_BURST;
                end
            end
            DEC_WR_BURST:
            begin
                // Write beats arrive at the host's pace
                if (beat_acc && mem_req.write)
                begin
                    mem_cmd.op = MEM_WRITE;
                    if (beats_left == AVMM_BURST_W'(1))
                        state_nxt = DEC_IDLE;
                end
            end
            DEC_RD_BURST:
            begin
                // One read per cycle, the host is held off meanwhile
                mem_cmd.op = MEM_READ;
                if (beats_left == AVMM_BURST_W'(1))
                    state_nxt = DEC_IDLE;
            end
            default: state_nxt = DEC_IDLE;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state      <= DEC_IDLE;
            wait_q     <= 1'b1;
            beat_idx   <= '0;
            beats_left <= '0;
        end
        else
        begin
            state  <= state_nxt;
            // Waitrequest is high exactly while a read burst is replayed
            wait_q <= (state_nxt == DEC_RD_BURST);
            if (state == DEC_IDLE && beat_acc)
            begin
                beat_idx   <= AVMM_BURST_W'(1);
                beats_left <= req_len - AVMM_BURST_W'(1);
            end
            else if (mem_cmd.op != MEM_IDLE)
            begin
                beat_idx   <= beat_idx + AVMM_BURST_W'(1);
                beats_left <= beats_left - AVMM_BURST_W'(1);
            end
        end
    end

    // Burst base address is latched from the first beat
    always_ff @(posedge clk)
    begin
        if (state == DEC_IDLE && beat_acc)
            base_addr <= mem_req.address;
    end

    a_one_strobe: assert property (@(posedge clk) disable iff (rst)
        !(mem_req.read && mem_req.write));

endmodule

// File: rtl/avmm_ram_exec.sv
// ------------------------------
// Memory command executor
// Word RAM with byte enables on write and
// one cycle of registered read latency
// ------------------------------

`timescale 1ns/1ps

module avmm_ram_exec import avmm_pkg::*; (
    input  logic      clk,
    input  logic      rst,

    input  mem_cmd_t  mem_cmd,
    output avmm_rsp_t ram_rsp
);

    // Storage array, one entry per bus word
    logic [AVMM_DATA_W-1:0] mem [AVMM_DEPTH];

    // Registered read port
    logic [AVMM_DATA_W-1:0] rdata_q;
    logic                   rvalid_q;

    // Decoded command strobes
    logic                   do_write;
    logic                   do_read;

    assign do_write = (mem_cmd.op == MEM_WRITE);
    assign do_read  = (mem_cmd.op == MEM_READ);

    // Each byte lane is written on its own enable
    // Lanes with a cleared enable keep their old contents
    always_ff @(posedge clk)
    begin
        if (do_write)
        begin
            for (int b = 0; b < AVMM_BE_W; b++)
            begin
                if (mem_cmd.be[b])
                    mem[mem_cmd.addr][b*8 +: 8] <= mem_cmd.wdata[b*8 +: 8];
            end
        end
    end

    // Read data is captured on the edge that sees the command
    // The decoder never issues a read and a write in the same cycle
    always_ff @(posedge clk)
    begin
        if (do_read)
            rdata_q <= mem[mem_cmd.addr];
    end

    // Valid strobe pulses once per read command
    always_ff @(posedge clk)
    begin
        if (rst)
            rvalid_q <= 1'b0;
        else
            rvalid_q <= do_read;
    end

    // Response beat toward the skid stage
    always_comb
    begin
        ram_rsp.readdata      = rdata_q;
        ram_rsp.readdatavalid = rvalid_q;
    end

    // Every read command returns its word on the next cycle
    a_read_latency: assert property (@(posedge clk) disable iff (rst)
        mem_cmd.op == MEM_READ |=> ram_rsp.readdatavalid);

endmodule

// File: rtl/avmm_mem_subsys.sv
// ------------------------------
// Avalon memory subsystem top
// Skid stage, burst decoder and word RAM
// ------------------------------

`timescale 1ns/1ps

module avmm_mem_subsys import avmm_pkg::*; #(
    parameter int SKID_REQ = 1,
    parameter int REG_RSP  = 1
) (
    input  logic      clk,
    input  logic      rst,

    input  avmm_req_t host_req,
    output logic      host_waitrequest,
    output avmm_rsp_t host_rsp
);

    // Request beat after the skid stage
    avmm_req_t mem_req;
    logic      mem_waitrequest;

    // Single-word command into the RAM
    mem_cmd_t  mem_cmd;

    // Read response out of the RAM
    avmm_rsp_t ram_rsp;

    avmm_if_skid #(
        .SKID_REQ(SKID_REQ),
        .REG_RSP (REG_RSP)
    ) if_skid_i (
        .clk             (clk),
        .rst             (rst),
        .host_req        (host_req),
        .host_waitrequest(host_waitrequest),
        .host_rsp        (host_rsp),
        .mem_req         (mem_req),
        .mem_waitrequest (mem_waitrequest),
        .mem_rsp         (ram_rsp)
    );

    // Bursts become one command per word here
    avmm_burst_decode burst_decode_i (
        .clk            (clk),
        .rst            (rst),
        .mem_req        (mem_req),
        .mem_waitrequest(mem_waitrequest),
        .mem_cmd        (mem_cmd)
    );

    avmm_ram_exec ram_exec_i (
        .clk    (clk),
        .rst    (rst),
        .mem_cmd(mem_cmd),
        .ram_rsp(ram_rsp)
    );

endmodule

// File: tb/tb_clk_gen.sv
// ------------------------------
// Testbench clock and reset source
// Free running clock, reset held high
// for a fixed number of cycles
// ------------------------------

`timescale 1ns/1ps

module tb_clk_gen #(
    parameter int PERIOD_NS    = 40,
    parameter int RESET_CYCLES = 10
) (
    output logic clk,
    output logic rst
);

    initial
    begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    // Reset drops on a rising edge like any other driven input
    initial
    begin
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;
    end

endmodule

// File: tb/avmm_mem_subsys_tb.sv
// ------------------------------
// Avalon memory subsystem testbench
// Single, byte enable, burst and random
// traffic checked against a memory model
// ------------------------------

`timescale 1ns/1ps

module avmm_mem_subsys_tb import avmm_pkg::*; ();

    localparam int CLK_PERIOD   = 40;
    localparam int RESET_CYCLES = 10;
    localparam int N_RAND_OPS   = 40;
    localparam int RAND_SPAN    = 64;
    localparam int DRAIN_CYCLES = 100;
    localparam logic [AVMM_ADDR_W-1:0] RAND_BASE = 10'd512;

    // Upper bound of issued beats: directed tests, random fill, random ops
    localparam int MAX_BEATS   = 2 + 5 + 10 + RAND_SPAN + N_RAND_OPS * 8;
    localparam int WATCHDOG_NS = CLK_PERIOD * 20 * MAX_BEATS + CLK_PERIOD * RESET_CYCLES;

    logic      clk;
    logic      rst;
    avmm_req_t host_req;
    logic      host_waitrequest;
    avmm_rsp_t host_rsp;

    // Model of the RAM contents and the words still owed to the host
    logic [AVMM_DATA_W-1:0] ref_mem [AVMM_DEPTH];
    logic [AVMM_DATA_W-1:0] exp_q [$];

    logic [31:0] lcg_state = 32'd85;
    int          err_count = 0;
    int          test_count = 0;
    int          beat_count = 0;
    int          rsp_count = 0;

    tb_clk_gen #(
        .PERIOD_NS   (CLK_PERIOD),
        .RESET_CYCLES(RESET_CYCLES)
    ) clk_gen_i (
        .clk(clk),
        .rst(rst)
    );

    avmm_mem_subsys #(
        .SKID_REQ(1),
        .REG_RSP (1)
    ) dut_i (
        .clk             (clk),
        .rst             (rst),
        .host_req        (host_req),
        .host_waitrequest(host_waitrequest),
        .host_rsp        (host_rsp)
    );

    // Responses are checked mid cycle, where they are stable
    a_rsp_expected: assert property (@(negedge clk) disable iff (rst)
        host_rsp.readdatavalid |-> exp_q.size() > 0)
    else
    begin
        $display("[ERROR] %0t: response arrived with no read outstanding", $time);
        err_count = err_count + 1;
    end

    a_rsp_data: assert property (@(negedge clk) disable iff (rst)
        host_rsp.readdatavalid && exp_q.size() > 0 |-> host_rsp.readdata == exp_q[0])
    else
    begin
        $display("[ERROR] %0t: readdata %h, expected %h", $time, host_rsp.readdata, exp_q[0]);
        err_count = err_count + 1;
    end

    a_reset_quiet: assert property (@(negedge clk)
        rst |-> !host_rsp.readdatavalid && host_waitrequest)
    else
    begin
        $display("[ERROR] %0t: response or ready seen during reset", $time);
        err_count = err_count + 1;
    end

    // The head word is retired on the edge that ends its response cycle
    always @(posedge clk)
    begin
        if (!rst && host_rsp.readdatavalid && exp_q.size() > 0)
        begin
            void'(exp_q.pop_front());
            rsp_count = rsp_count + 1;
        end
    end

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    // Holds the beat until an edge where waitrequest is low
    task automatic send_beat(input avmm_req_t beat);
        host_req <= beat;
        @(posedge clk);
        while (host_waitrequest)
            @(posedge clk);
        beat_count = beat_count + 1;
    endtask

    task automatic go_idle();
        host_req <= '0;
    endtask

    // One write beat, idx is its position within the burst
    task automatic send_write(input logic [AVMM_ADDR_W-1:0] addr, input int len,
                              input int idx, input logic [AVMM_DATA_W-1:0] data,
                              input logic [AVMM_BE_W-1:0] be);
        avmm_req_t              beat;
        logic [AVMM_ADDR_W-1:0] a;
        beat            = '0;
        beat.address    = addr;
        beat.burstcount = AVMM_BURST_W'(len);
        beat.writedata  = data;
        beat.byteenable = be;
        beat.write      = 1'b1;
        send_beat(beat);
        a = addr + AVMM_ADDR_W'(idx);
        for (int b = 0; b < AVMM_BE_W; b++)
        begin
            if (be[b])
                ref_mem[a][b*8 +: 8] = data[b*8 +: 8];
        end
    endtask

    task automatic write_burst(input logic [AVMM_ADDR_W-1:0] addr, input int len);
        for (int i = 0; i < len; i++)
            send_write(addr, len, i, next_rand(), '1);
    endtask

    // The words owed are fixed by the model at the moment the read is taken
    task automatic read_burst(input logic [AVMM_ADDR_W-1:0] addr, input int len);
        avmm_req_t              beat;
        logic [AVMM_ADDR_W-1:0] a;
        beat            = '0;
        beat.address    = addr;
        beat.burstcount = AVMM_BURST_W'(len);
        beat.read       = 1'b1;
        send_beat(beat);
        for (int i = 0; i < len; i++)
        begin
            a = addr + AVMM_ADDR_W'(i);
            exp_q.push_back(ref_mem[a]);
        end
    endtask

    task automatic wait_responses();
        int cycles;
        cycles = 0;
        while (exp_q.size() != 0 && cycles < DRAIN_CYCLES)
        begin
            @(posedge clk);
            cycles = cycles + 1;
        end
        if (exp_q.size() != 0)
        begin
            $display("%0d read responses never arrived", exp_q.size());
            err_count = err_count + 1;
        end
    endtask

    task automatic finish_test(input string name, input int errs_before);
        test_count = test_count + 1;
        $display("Test %s done with %0d errors", name, err_count - errs_before);
    endtask

    task automatic check_reset();
        int errs_before;
        int cycles;
        errs_before = err_count;
        cycles = 0;
        @(posedge clk);
        while (rst)
            @(posedge clk);
        while (host_waitrequest && cycles < 8)
        begin
            @(posedge clk);
            cycles = cycles + 1;
        end
        if (host_waitrequest)
        begin
            $display("Host waitrequest still high %0d cycles after reset", cycles);
            err_count = err_count + 1;
        end
        finish_test("reset", errs_before);
    endtask

    task automatic single_rw();
        int errs_before;
        errs_before = err_count;
        send_write(10'd5, 1, 0, 32'hcafe_f00d, '1);
        read_burst(10'd5, 1);
        go_idle();
        wait_responses();
        finish_test("single_rw", errs_before);
    endtask

    // Each byte ends up from the latest write whose enable covered it
    task automatic byte_enables();
        int errs_before;
        errs_before = err_count;
        send_write(10'd20, 1, 0, 32'h1122_3344, 4'b1111);
        send_write(10'd20, 1, 0, 32'haaaa_aaaa, 4'b0001);
        send_write(10'd20, 1, 0, 32'h5555_5555, 4'b0110);
        send_write(10'd20, 1, 0, 32'h0f0f_0f0f, 4'b1010);
        read_burst(10'd20, 1);
        go_idle();
        wait_responses();
        finish_test("byte_enables", errs_before);
    endtask

    task automatic burst_rw();
        int errs_before;
        errs_before = err_count;
        write_burst(10'd100, 8);
        read_burst(10'd100, 8);
        read_burst(10'd103, 3);
        go_idle();
        wait_responses();
        finish_test("burst_rw", errs_before);
    endtask

    // The window is filled first so that no read returns an unwritten word
    task automatic random_traffic();
        int                     errs_before;
        int                     len;
        logic [31:0]            r;
        logic [31:0]            data;
        logic [AVMM_ADDR_W-1:0] addr;
        errs_before = err_count;
        for (int i = 0; i < RAND_SPAN; i += 8)
            write_burst(RAND_BASE + AVMM_ADDR_W'(i), 8);
        for (int n = 0; n < N_RAND_OPS; n++)
        begin
            r    = next_rand();
            addr = RAND_BASE + AVMM_ADDR_W'(r[31:24] % 8'd57);
            len  = int'(r[22:20]) + 1;
            case (r[17:16])
                2'd0:
                begin
                    data = next_rand();
                    send_write(addr, 1, 0, data, data[15:12]);
                end
                2'd1: write_burst(addr, len);
                default: read_burst(addr, len);
            endcase
        end
        go_idle();
        wait_responses();
        finish_test("random_traffic", errs_before);
    endtask

    initial
    begin
        host_req = '0;
        check_reset();
        single_rw();
        byte_enables();
        burst_rw();
        random_traffic();
        repeat (4) @(posedge clk);
        $display("Tests %0d, beats %0d, responses %0d, errors %0d",
                 test_count, beat_count, rsp_count, err_count);
        if (err_count == 0)
            $display("Simulation passed");
        else
            $display("Simulation failed");
        $finish;
    end

    initial
    begin
        #(WATCHDOG_NS);
        $display("Watchdog expired after %0d ns with the run still going", WATCHDOG_NS);
        $display("Simulation failed");
        $finish;
    end

endmodule

// File: avmm_mem_subsys.f
rtl/avmm_pkg.sv
rtl/avmm_ready_skid.sv
rtl/avmm_if_skid.sv
rtl/avmm_burst_decode.sv
rtl/avmm_ram_exec.sv
rtl/avmm_mem_subsys.sv
tb/tb_clk_gen.sv
tb/avmm_mem_subsys_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the Avalon memory subsystem testbench with Verilator and runs it.
# The run counts as failed if any step fails or the log holds the fail message.

set -u
cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG_FILE=sim.log
FAIL_MSG="Simulation failed"

verilator --binary --timing --assert \
    -f avmm_mem_subsys.f \
    --top-module avmm_mem_subsys_tb \
    -Mdir "$BUILD_DIR" -o sim_top
status=$?
if [ "$status" -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

"./$BUILD_DIR/sim_top" 2>&1 | tee "$LOG_FILE"
status=${PIPESTATUS[0]}
if [ "$status" -ne 0 ]; then
    echo "Simulation executable exited with status $status"
    exit 1
fi

if grep -q "$FAIL_MSG" "$LOG_FILE"; then
    echo "Fail message found in $LOG_FILE"
    exit 1
fi

exit 0
